//--- common/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// datapath width, RV32 immediates assume 32.
`define OPERAND_WIDTH 32

// number of identical execute lanes, 2 or more.
`define LANE_COUNT 4

`define LANE_IDX_W $clog2(`LANE_COUNT)

// one restoring step per operand bit.
`define DIV_STEPS `OPERAND_WIDTH

`endif

//--- common/exec_pkg.sv
`default_nettype none

`include "exec_config.svh"

package exec_pkg;

        typedef enum logic [4:0] {
                ADD,
                SUB,
                SLL,
                SRL,
                SRA,
                XOR,
                OR,
                AND,
                SLT,
                SLTU,
                LUI,
                AUIPC,
                MUL,
                MULH,
                DIV,
                DIVU,
                REM,
                REMU
        } alu_op_t;

        typedef struct packed {
                alu_op_t                   op;
                logic [`OPERAND_WIDTH-1:0] a;
                logic [`OPERAND_WIDTH-1:0] b;
        } exec_req_t;

        typedef struct packed {
                logic [`OPERAND_WIDTH-1:0] result;
                logic                      zero;
        } lane_rsp_t;

        // cluster output, same layout as a lane result.
        typedef struct packed {
                logic [`OPERAND_WIDTH-1:0] result;
                logic                      zero;
        } exec_rsp_t;

endpackage

`default_nettype wire

//--- hw/alu/div_int.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module div_int
(
        input  logic                      clk,
        input  logic                      rst_n,
        input  logic                      start,
        input  logic [`OPERAND_WIDTH-1:0] a,
        input  logic [`OPERAND_WIDTH-1:0] b,
        input  logic                      is_signed,
        output logic                      busy,
        output logic                      done,
        output logic [`OPERAND_WIDTH-1:0] quot,
        output logic [`OPERAND_WIDTH-1:0] rem
);

localparam int W     = `OPERAND_WIDTH;
localparam int CNT_W = $clog2(`DIV_STEPS);

logic [W-1:0]     a_mag, b_mag;
logic [W-1:0]     divisor_q, quo_q, rem_q;
logic             neg_quot_q, neg_rem_q;
logic [CNT_W-1:0] count;
logic [W:0]       partial, diff;

assign a_mag = (is_signed && a[W-1]) ? -a : a;
assign b_mag = (is_signed && b[W-1]) ? -b : b;

// bring down the next dividend bit and try the subtraction.
assign partial = {rem_q, quo_q[W-1]};
assign diff    = partial - {1'b0, divisor_q};

always_ff @(posedge clk)
begin
        if (!rst_n)
        begin
                busy  <= 1'b0;
                done  <= 1'b0;
                count <= '0;
        end
        else
        begin
                done <= 1'b0;
                if (start && !busy)
                begin
                        busy  <= 1'b1;
                        count <= '0;
                end
                else if (busy)
                begin
                        count <= count + 1'b1;
                        if (count == CNT_W'(`DIV_STEPS - 1))
                        begin
                                busy <= 1'b0;
                                done <= 1'b1;
                        end
                end
        end
end

always_ff @(posedge clk)
begin
        if (start && !busy)
        begin
                quo_q      <= a_mag;
                rem_q      <= '0;
                divisor_q  <= b_mag;
                // a zero divisor keeps the all ones quotient positive.
                neg_quot_q <= is_signed && (a[W-1] ^ b[W-1]) && (b != '0);
                neg_rem_q  <= is_signed && a[W-1];
        end
        else if (busy)
        begin
                if (!diff[W])
                begin
                        rem_q <= diff[W-1:0];
                        quo_q <= {quo_q[W-2:0], 1'b1};
                end
                else
                begin
                        rem_q <= partial[W-1:0]; // restore.
                        quo_q <= {quo_q[W-2:0], 1'b0};
                end
        end
end

// most negative by minus one falls out as the dividend with remainder 0.
assign quot = neg_quot_q ? -quo_q : quo_q;
assign rem  = neg_rem_q ? -rem_q : rem_q;

endmodule

`default_nettype wire

//--- hw/alu/alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module alu_lane import exec_pkg::*;
(
        input  logic      clk,
        input  logic      rst_n,
        input  logic      issue,
        input  exec_req_t req,
        input  logic      retire,
        output logic      busy,
        output logic      done,
        output lane_rsp_t rsp
);

localparam int W       = `OPERAND_WIDTH;
localparam int SHAMT_W = $clog2(`OPERAND_WIDTH);

logic [W-1:0]          alu_result, div_result;
logic signed [2*W-1:0] mul_full;
logic [SHAMT_W-1:0]    shamt;
logic                  is_div_in, div_start, div_signed;
logic                  div_busy, div_done;
logic [W-1:0]          div_quot, div_rem;
alu_op_t               op_q;

assign is_div_in  = req.op inside {DIV, DIVU, REM, REMU};
assign div_signed = (req.op == DIV) || (req.op == REM);
assign div_start  = issue && is_div_in;

assign shamt    = req.b[SHAMT_W-1:0];
assign mul_full = $signed(req.a) * $signed(req.b);

always_comb
begin
        case (req.op)
                ADD:    alu_result = req.a + req.b;
                SUB:    alu_result = req.a - req.b;
                SLL:    alu_result = req.a << shamt;
                SRL:    alu_result = req.a >> shamt;
                SRA:    alu_result = $signed(req.a) >>> shamt;
                XOR:    alu_result = req.a ^ req.b;
                OR:     alu_result = req.a | req.b;
                AND:    alu_result = req.a & req.b;
                SLT:    alu_result = W'($signed(req.a) < $signed(req.b));
                SLTU:   alu_result = W'(req.a < req.b);
                LUI:    alu_result = {req.b[19:0], 12'h0};
                AUIPC:  alu_result = req.a + {req.b[19:0], 12'h0};
                MUL:    alu_result = mul_full[W-1:0];
                MULH:   alu_result = mul_full[2*W-1:W]; // signed high half.
                default:
                        alu_result = '0; // divides finish in div_int.
        endcase
end

assign div_result = (op_q == DIV || op_q == DIVU) ? div_quot : div_rem;

always_ff @(posedge clk)
begin
        if (!rst_n)
        begin
                busy <= 1'b0;
                done <= 1'b0;
        end
        else
        begin
                if (issue)
                        busy <= 1'b1;
                else if (retire)
                        busy <= 1'b0;

                if (retire)
                        done <= 1'b0;
                else if ((issue && !is_div_in) || div_done)
                        done <= 1'b1;
        end
end

always_ff @(posedge clk)
begin
        if (issue)
                op_q <= req.op;

        if (issue && !is_div_in)
        begin
                rsp.result <= alu_result;
                rsp.zero   <= (alu_result == '0);
        end
        else if (div_done)
        begin
                rsp.result <= div_result;
                rsp.zero   <= (div_result == '0);
        end
end

div_int div_i
(
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .a         (req.a),
        .b         (req.b),
        .is_signed (div_signed),
        .busy      (div_busy),
        .done      (div_done),
        .quot      (div_quot),
        .rem       (div_rem)
);

// dispatch only picks an idle lane, whose divider has already finished.
issue_idle: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> !busy && !div_busy);

retire_done: assert property (@(posedge clk) disable iff (!rst_n)
        retire |-> done);

endmodule

`default_nettype wire

//--- hw/issue_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module issue_dispatch import exec_pkg::*;
(
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    in_valid,
        input  exec_req_t               in_req,
        input  logic [`LANE_COUNT-1:0]  lane_busy,
        output logic                    stall,
        output logic [`LANE_COUNT-1:0]  issue,
        output exec_req_t               issue_req,
        output logic                    push,
        output logic [`LANE_IDX_W-1:0]  push_lane
);

localparam int IDX_W = `LANE_IDX_W;

logic [`LANE_COUNT-1:0] lane_free;
logic [IDX_W-1:0]       rr_ptr, pick;
logic                   accept;

// a lane issued this cycle only shows busy from the next one.
assign lane_free = ~(lane_busy | issue);
assign stall     = ~|lane_free;
assign accept    = in_valid && !stall;

always_comb
begin : pick_lane
        int   idx;
        logic found;

        found = 1'b0;
        pick  = rr_ptr;
        for (int i = 0; i < `LANE_COUNT; i++)
        begin
                idx = (int'(rr_ptr) + i) % `LANE_COUNT;
                if (!found && lane_free[idx])
                begin
                        found = 1'b1;
                        pick  = IDX_W'(idx);
                end
        end
end

always_ff @(posedge clk)
begin
        if (!rst_n)
        begin
                issue  <= '0;
                push   <= 1'b0;
                rr_ptr <= '0;
        end
        else
        begin
                issue <= accept ? (`LANE_COUNT'(1) << pick) : '0;
                push  <= accept;
                if (accept)
                        rr_ptr <= (pick == IDX_W'(`LANE_COUNT - 1)) ? '0 : pick + 1'b1;
        end
end

always_ff @(posedge clk)
begin
        if (accept)
        begin
                issue_req <= in_req;
                push_lane <= pick; // same cycle as the issue strobe.
        end
end

issue_onehot_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(issue) && ((issue & lane_busy) == '0));

endmodule

`default_nettype wire

//--- hw/result_collect.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module result_collect import exec_pkg::*;
(
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    push,
        input  logic [`LANE_IDX_W-1:0]  push_lane,
        input  logic [`LANE_COUNT-1:0]  lane_done,
        input  lane_rsp_t               lane_rsp [`LANE_COUNT],
        output logic [`LANE_COUNT-1:0]  retire,
        output logic                    out_valid,
        output exec_rsp_t               out_rsp
);

localparam int IDX_W = `LANE_IDX_W;
localparam int CNT_W = $clog2(`LANE_COUNT + 1);

logic [IDX_W-1:0] order_q [`LANE_COUNT];
logic [IDX_W-1:0] rd_ptr, wr_ptr, head_lane;
logic [CNT_W-1:0] count;
logic             pop;

function automatic logic [IDX_W-1:0] ptr_next(input logic [IDX_W-1:0] p);
        return (p == IDX_W'(`LANE_COUNT - 1)) ? '0 : p + 1'b1;
endfunction

assign head_lane = order_q[rd_ptr];
assign pop       = (count != '0) && lane_done[head_lane];
assign retire    = pop ? (`LANE_COUNT'(1) << head_lane) : '0;

always_ff @(posedge clk)
begin
        if (!rst_n)
        begin
                rd_ptr    <= '0;
                wr_ptr    <= '0;
                count     <= '0;
                out_valid <= 1'b0;
        end
        else
        begin
                out_valid <= pop;
                if (push)
                        wr_ptr <= ptr_next(wr_ptr);
                if (pop)
                        rd_ptr <= ptr_next(rd_ptr);
                case ({push, pop})
                        2'b10:   count <= count + 1'b1;
                        2'b01:   count <= count - 1'b1;
                        default: count <= count;
                endcase
        end
end

always_ff @(posedge clk)
begin
        if (push)
                order_q[wr_ptr] <= push_lane;
        if (pop)
        begin
                out_rsp.result <= lane_rsp[head_lane].result;
                out_rsp.zero   <= lane_rsp[head_lane].zero;
        end
end

// stall holds dispatch off while every lane is still queued.
no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> count != CNT_W'(`LANE_COUNT));

// a lane can only finish work that was queued here first.
no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        count == '0 |-> lane_done == '0);

endmodule

`default_nettype wire

//--- hw/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_cluster import exec_pkg::*;
(
        input  logic      clk,
        input  logic      rst_n,
        input  logic      in_valid,
        input  exec_req_t in_req,
        output logic      stall,
        output logic      out_valid,
        output exec_rsp_t out_rsp
);

logic [`LANE_COUNT-1:0] issue, lane_busy, lane_done, retire;
logic                   push;
logic [`LANE_IDX_W-1:0] push_lane;
exec_req_t              issue_req;
lane_rsp_t              lane_rsp [`LANE_COUNT];

issue_dispatch dispatch_i
(
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .lane_busy (lane_busy),
        .stall     (stall),
        .issue     (issue),
        .issue_req (issue_req),
        .push      (push),
        .push_lane (push_lane)
);

for (genvar i = 0; i < `LANE_COUNT; i++)
begin : g_lane
        alu_lane lane_i
        (
                .clk    (clk),
                .rst_n  (rst_n),
                .issue  (issue[i]),
                .req    (issue_req), // shared, only the strobed lane takes it.
                .retire (retire[i]),
                .busy   (lane_busy[i]),
                .done   (lane_done[i]),
                .rsp    (lane_rsp[i])
        );
end

result_collect collect_i
(
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_lane (push_lane),
        .lane_done (lane_done),
        .lane_rsp  (lane_rsp),
        .retire    (retire),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
);

endmodule

`default_nettype wire

//--- tests/exec_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_cluster_tb import exec_pkg::*;
();

localparam int W         = `OPERAND_WIDTH;
localparam int SEED      = 32'hf967_c2b1;
localparam int N_FAST    = 40;
localparam int N_FORCED  = 8;
localparam int N_DIV     = 24;
localparam int N_MIX     = 60;
localparam int TOTAL_OPS = 1 + N_FAST + N_FORCED + N_DIV + N_MIX;
localparam int WATCHDOG_CYCLES = TOTAL_OPS * (`DIV_STEPS + 4) * `LANE_COUNT;
localparam int FAST_LAT  = 2;
localparam int DIV_LAT   = `DIV_STEPS + 3;

logic      clk = 1'b0;
logic      rst_n;
logic      in_valid;
exec_req_t in_req;
logic      stall;
logic      out_valid;
exec_rsp_t out_rsp;

exec_rsp_t expected_q [$];
int        cycle = 0;
int        errors = 0;
int        checks = 0;
int        tests_run = 0;
int        n_accepted = 0;
int        n_dropped = 0;
int        out_count = 0;
int        last_accept_cycle = 0;
int        last_out_cycle = 0;
logic      stall_seen = 1'b0;

exec_cluster exec_cluster_i
(
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .stall     (stall),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
);

always #10 clk = ~clk;

always @(posedge clk)
        cycle <= cycle + 1;

task automatic check_value(input string what, input logic [31:0] actual,
                           input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
                errors++;
                $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what,
                         actual, expected);
        end
endtask

task automatic report_test(input string name, input int mark);
        tests_run++;
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errors == mark) ? "ok" : "failed", errors - mark);
endtask

// expected response from the RV32IM rules.
function automatic exec_rsp_t reference_rsp(input exec_req_t r);
        logic [W-1:0]      a, b, res, upper;
        logic signed [63:0] prod;
        logic              ovf;
        exec_rsp_t         rsp;

        a     = r.a;
        b     = r.b;
        upper = {b[19:0], 12'h000};
        prod  = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        ovf   = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (r.op)
                ADD:    res = a + b;
                SUB:    res = a - b;
                SLL:    res = a << b[4:0];
                SRL:    res = a >> b[4:0];
                SRA:    res = $signed(a) >>> b[4:0];
                XOR:    res = a ^ b;
                OR:     res = a | b;
                AND:    res = a & b;
                SLT:    res = {31'b0, $signed(a) < $signed(b)};
                SLTU:   res = {31'b0, a < b};
                LUI:    res = upper;
                AUIPC:  res = a + upper;
                MUL:    res = prod[31:0];
                MULH:   res = prod[63:32];
                DIV:    res = (b == 0) ? '1 : ovf ? a : 32'($signed(a) / $signed(b));
                DIVU:   res = (b == 0) ? '1 : a / b;
                REM:    res = (b == 0) ? a : ovf ? '0 : 32'($signed(a) % $signed(b));
                REMU:   res = (b == 0) ? a : a % b;
                default:
                        res = '0;
        endcase
        rsp.result = res;
        rsp.zero   = (res == 0);
        return rsp;
endfunction

function automatic exec_req_t rand_req(input logic div_op);
        exec_req_t r;

        if (div_op)
                r.op = alu_op_t'(5'(DIV) + 5'($urandom_range(3, 0)));
        else
                r.op = alu_op_t'(5'($urandom_range(13, 0)));
        r.a = $urandom;
        // small divisors now and then keep quotients away from 0.
        r.b = ($urandom_range(3, 0) == 0) ? 32'($urandom_range(15, 0)) : $urandom;
        return r;
endfunction

// called on a falling edge and returns on the falling edge after acceptance.
task automatic offer(input exec_req_t r);
        in_valid = 1'b1;
        in_req   = r;
        while (stall)
        begin
                stall_seen = 1'b1;
                n_dropped++; // dropped at the next edge and offered again.
                @(negedge clk);
        end
        expected_q.push_back(reference_rsp(r));
        n_accepted++;
        last_accept_cycle = cycle + 1;
        @(negedge clk);
        in_valid = 1'b0;
endtask

task automatic wait_drain(input int limit);
        int waited;

        waited = 0;
        @(posedge clk);
        while (out_count != n_accepted && waited < limit)
        begin
                @(posedge clk);
                waited++;
        end
        if (out_count != n_accepted)
        begin
                errors++;
                $display("no result after %0d cycles, %0d of %0d results arrived",
                         limit, out_count, n_accepted);
        end
        @(negedge clk);
endtask

task automatic send_lone(input exec_req_t r, input int latency);
        offer(r);
        wait_drain(latency + 10);
        check_value("latency", 32'(last_out_cycle - last_accept_cycle), 32'(latency));
endtask

always @(negedge clk)
begin : watch_output
        exec_rsp_t exp;

        if (rst_n && out_valid)
        begin
                out_count++;
                last_out_cycle = cycle;
                if (expected_q.size() == 0)
                begin
                        errors++;
                        $display("output at %0t ns while no accepted request was pending", $time);
                end
                else
                begin
                        exp = expected_q.pop_front();
                        check_value("result", out_rsp.result, exp.result);
                        check_value("zero flag", 32'(out_rsp.zero), 32'(exp.zero));
                end
        end
end

initial
begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
end

initial
begin : run_tests
        int        mark;
        exec_req_t r;

        void'($urandom(SEED));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;

        mark = errors;
        repeat (3)
        begin
                @(negedge clk);
                check_value("stall in reset", 32'(stall), 0);
                check_value("out_valid in reset", 32'(out_valid), 0);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_value("stall after reset", 32'(stall), 0);
        check_value("out_valid after reset", 32'(out_valid), 0);
        report_test("reset state", mark);

        mark = errors;
        r.op = ADD;
        r.a  = $urandom;
        r.b  = -r.a; // sum of zero.
        send_lone(r, FAST_LAT);
        report_test("single cycle latency", mark);

        mark = errors;
        repeat (N_FAST)
                send_lone(rand_req(1'b0), FAST_LAT);
        report_test("alu operations", mark);

        mark = errors;
        for (int k = 0; k < 4; k++)
        begin
                r.op = alu_op_t'(5'(DIV) + 5'(k));
                r.a  = $urandom;
                r.b  = '0;
                send_lone(r, DIV_LAT);
                r.a  = 32'h8000_0000;
                r.b  = 32'hffff_ffff;
                send_lone(r, DIV_LAT);
        end
        repeat (N_DIV)
                send_lone(rand_req(1'b1), DIV_LAT);
        report_test("divide operations", mark);

        mark = errors;
        stall_seen = 1'b0;
        repeat (N_MIX)
                offer(rand_req($urandom_range(99, 0) < 30));
        wait_drain(N_MIX * (`DIV_STEPS + 4));
        // a dropped request taken in anyway would show up as a late extra result.
        repeat (DIV_LAT + 2)
                @(negedge clk);
        check_value("result count", 32'(out_count), 32'(n_accepted));
        check_value("stall seen", 32'(stall_seen), 1);
        report_test("ordering and stall", mark);

        if (expected_q.size() != 0)
        begin
                errors++;
                $display("%0d accepted requests never produced a result", expected_q.size());
        end
        $display("tests %0d, checks %0d, accepted %0d, dropped %0d, errors %0d",
                 tests_run, checks, n_accepted, n_dropped, errors);
        if (errors == 0)
                $display("Result: PASSED");
        else
                $display("Result: FAILED");
        $finish;
end

endmodule

`default_nettype wire

//--- exec_cluster.f
+incdir+common
common/exec_pkg.sv
hw/alu/div_int.sv
hw/alu/alu_lane.sv
hw/issue_dispatch.sv
hw/result_collect.sv
hw/exec_cluster.sv
tests/exec_cluster_tb.sv

//--- Makefile
TOP := exec_cluster_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timescale 1ns/1ps -f exec_cluster.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

lint:
	verilator --lint-only --timescale 1ns/1ps -f exec_cluster.f --top-module exec_cluster

clean:
	rm -rf obj_dir
